// ==== sources.f ====
+incdir+include
design/pacman_types_pkg.sv
design/pacman_video_pkg.sv
design/key_direction_latch.sv
design/pacman_move_ctrl.sv
design/collision_detect.sv
design/map_ram_writer.sv
design/tile_map_ram.sv
design/tile_renderer.sv
design/pacman_game_top.sv
verif/pacman_game_properties.sv
verif/pacman_game_tb.sv

// ==== Bender.yml ====
package:
  name: pacman_game

sources:
  - include_dirs:
      - include
    files:
      - design/pacman_types_pkg.sv
      - design/pacman_video_pkg.sv
      - design/key_direction_latch.sv
      - design/pacman_move_ctrl.sv
      - design/collision_detect.sv
      - design/map_ram_writer.sv
      - design/tile_map_ram.sv
      - design/tile_renderer.sv
      - design/pacman_game_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/pacman_game_properties.sv
      - verif/pacman_game_tb.sv

// ==== verif/pacman_game_tb.sv ====
`include "pacman_consts.svh"

module pacman_game_tb;
	import pacman_types_pkg::*;
	import pacman_video_pkg::*;

	logic clock_50;
	logic rst_n;
	logic key_up;
	logic key_down;
	logic key_left;
	logic key_right;
	logic step;
	pixel_pos_t pixel;
	rgb_t rgb;
	tile_pos_t pacman_pos;
	logic [10:0] pill_count;
	logic game_won;
	coll_e last_coll;
	logic busy;
	logic ready;

	// outputs as seen at the falling edge
	logic busy_s;
	logic ready_s;
	tile_pos_t pos_s;
	logic [10:0] count_s;
	coll_e coll_s;
	logic won_s;

	// model state
	tile_e map_m [0:`MAP_ROWS-1][0:`MAP_COLS-1];
	tile_pos_t pos_m;
	dir_e dir_m;
	int pills_m;
	// pixel now driven, one and two cycles back
	pixel_pos_t cur_pix;
	pixel_pos_t pipe0;
	pixel_pos_t pipe1;
	int quiet;

	logic [15:0] lfsr;
	int mismatches;
	int timeouts;
	logic timed_out;

	pacman_game_top pacman_game_top_inst (.clock_50(clock_50), .rst_n(rst_n),
		.key_up(key_up), .key_down(key_down), .key_left(key_left), .key_right(key_right),
		.step(step), .pixel(pixel), .rgb(rgb), .pacman_pos(pacman_pos),
		.pill_count(pill_count), .game_won(game_won), .last_coll(last_coll),
		.busy(busy), .ready(ready));

	always #5 clock_50 = ~clock_50;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic next_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] draw_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
		return v;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %0h expected %0h", $time, what, got, exp);
			mismatches++;
		end
	endtask

	// border walls, pillar grid on even row and column, pills elsewhere
	task automatic build_maze();
		for (int r = 0; r < `MAP_ROWS; r++) begin
			for (int c = 0; c < `MAP_COLS; c++) begin
				if (r == 0 || r == `MAP_ROWS - 1 || c == 0 || c == `MAP_COLS - 1)
					map_m[r][c] = tile_wall;
				else if (r % 2 == 0 && c % 2 == 0)
					map_m[r][c] = tile_wall;
				else
					map_m[r][c] = tile_pill;
			end
		end
		map_m[`START_Y][`START_X] = tile_pac;
	endtask

	function automatic rgb_t model_rgb(input pixel_pos_t p);
		int lx;
		int ly;
		tile_e t;
		rgb_t c;
		c = '0;
		// off-map pixels stay black
		if (p.x < `MAP_COLS * `TILE_PIX && p.y < `MAP_ROWS * `TILE_PIX) begin
			t = map_m[p.y / `TILE_PIX][p.x / `TILE_PIX];
			lx = p.x % `TILE_PIX;
			ly = p.y % `TILE_PIX;
			if (t == tile_wall)
				c = `COLOR_WALL;
			else if (t == tile_pac)
				c = `COLOR_PAC;
			else if (t == tile_pill && lx >= `PILL_LO && lx <= `PILL_HI &&
				ly >= `PILL_LO && ly <= `PILL_HI)
				c = `COLOR_PILL;
		end
		return c;
	endfunction

	// one clock, sample and check on the falling edge, drive on the rising edge
	task automatic tick();
		@(negedge clock_50);
		busy_s = busy;
		ready_s = ready;
		pos_s = pacman_pos;
		count_s = pill_count;
		coll_s = last_coll;
		won_s = game_won;
		// map must be still over the read cycle of the pixel under test
		if (ready_s && !busy_s) quiet++;
		else quiet = 0;
		if (quiet >= 3) check_value(rgb, model_rgb(pipe1), "rgb of pixel two cycles back");
		@(posedge clock_50);
		pipe1 = pipe0;
		pipe0 = cur_pix;
		cur_pix.x = 10'(draw_bits(10));
		cur_pix.y = 9'(draw_bits(9));
		pixel <= cur_pix;
	endtask

	task automatic wait_for_busy(input logic level, input string what);
		int cnt;
		cnt = 0;
		while (busy_s !== level && cnt < 50) begin
			tick();
			cnt++;
		end
		if (busy_s !== level) begin
			$display("timeout at %0t: %s", $time, what);
			timeouts++;
			timed_out = 1'b1;
		end
	endtask

	// a finished step, outcome follows from the target tile
	task automatic step_model();
		tile_pos_t nxt;
		tile_e t;
		coll_e exp_coll;
		nxt = pos_m;
		case (dir_m)
			dir_up: nxt.y = pos_m.y - 5'd1;
			dir_down: nxt.y = pos_m.y + 5'd1;
			dir_left: nxt.x = pos_m.x - 6'd1;
			dir_right: nxt.x = pos_m.x + 6'd1;
			default: nxt = pos_m;
		endcase
		t = map_m[nxt.y][nxt.x];
		if (t == tile_wall) begin
			exp_coll = coll_wall;
		end else begin
			exp_coll = (t == tile_pill) ? coll_pill : coll_none;
			if (t == tile_pill) pills_m++;
			map_m[pos_m.y][pos_m.x] = tile_empty;
			map_m[nxt.y][nxt.x] = tile_pac;
			pos_m = nxt;
		end
		check_value(pos_s, pos_m, "pacman_pos after a step");
		check_value(coll_s, exp_coll, "last_coll after a step");
		check_value(count_s, pills_m, "pill_count after a step");
		check_value(won_s, pills_m == `PILL_TOTAL, "game_won after a step");
	endtask

	task automatic play_turn();
		logic [3:0] pat;
		logic [2:0] idle_n;
		logic extra;
		logic taken;
		pat = 4'(draw_bits(4));
		idle_n = 3'(draw_bits(3));
		extra = draw_bits(1);
		tick();
		{key_up, key_down, key_left, key_right} <= pat;
		// priority up, down, left, right, held on no key
		if (pat[3]) dir_m = dir_up;
		else if (pat[2]) dir_m = dir_down;
		else if (pat[1]) dir_m = dir_left;
		else if (pat[0]) dir_m = dir_right;
		repeat (idle_n) tick();
		tick();
		step <= 1'b1;
		taken = (dir_m != dir_none);
		tick();
		step <= 1'b0;
		// second pulse lands while the step is still probing
		if (extra) begin
			tick();
			step <= 1'b1;
			tick();
			step <= 1'b0;
		end
		if (taken) begin
			wait_for_busy(1'b1, "busy did not rise after a step");
			if (!timed_out) wait_for_busy(1'b0, "busy did not fall at the end of a step");
			if (!timed_out) step_model();
		end else begin
			tick();
			check_value(busy_s, 1'b0, "busy after a step with no direction");
			check_value(pos_s, pos_m, "pacman_pos after an ignored step");
		end
	endtask

	initial begin
		int cnt;
		clock_50 = 1'b0;
		rst_n = 1'b0;
		key_up = 1'b0;
		key_down = 1'b0;
		key_left = 1'b0;
		key_right = 1'b0;
		step = 1'b0;
		pixel = '0;
		lfsr = 16'd52;
		cur_pix = '0;
		pipe0 = '0;
		pipe1 = '0;
		quiet = 0;
		dir_m = dir_none;
		pos_m = '{x: 6'(`START_X), y: 5'(`START_Y)};
		pills_m = 0;
		mismatches = 0;
		timeouts = 0;
		timed_out = 1'b0;
		build_maze();

		repeat (16) tick();
		rst_n <= 1'b1;

		// fill of 30 rows
		cnt = 0;
		while (!ready_s && cnt < 40) begin
			tick();
			cnt++;
		end
		if (!ready_s) begin
			$display("timeout at %0t: ready did not rise within 40 cycles", $time);
			timeouts++;
			timed_out = 1'b1;
		end else begin
			check_value(pos_s, pos_m, "pacman_pos after fill");
			check_value(count_s, 0, "pill_count after fill");
			check_value(won_s, 1'b0, "game_won after fill");
			check_value(busy_s, 1'b0, "busy after fill");
		end

		if (!timed_out) begin
			// no key pressed yet, so the step goes nowhere
			tick();
			step <= 1'b1;
			tick();
			step <= 1'b0;
			repeat (3) begin
				tick();
				check_value(busy_s, 1'b0, "busy after a step before any key");
			end
			check_value(pos_s, pos_m, "pacman_pos after a step before any key");
			// starting maze through the renderer
			repeat (200) tick();
		end

		for (int turn = 0; turn < 400 && !timed_out; turn++) play_turn();
		repeat (4) tick();

		$display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatches, timeouts, pacman_game_top_inst.pacman_game_properties_inst.failures);
		if (mismatches == 0 && timeouts == 0 &&
			pacman_game_top_inst.pacman_game_properties_inst.failures == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== verif/pacman_game_properties.sv ====
module pacman_game_properties (
	input logic clock_50,
	input logic rst_n,
	input logic ready,
	input logic busy,
	input logic [10:0] pill_count,
	input logic game_won,
	input pacman_video_pkg::rgb_t rgb
);

	// failed assertions so far
	int failures = 0;
	// pill count in the cycle the current step was taken
	logic [10:0] count_at_take;

	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			count_at_take <= '0;
		end else if (!busy) begin
			count_at_take <= pill_count;
		end
	end

	// a step can only run on a filled map
	busy_needs_ready: assert property (@(posedge clock_50) disable iff (!rst_n)
		busy |-> ready)
		else begin
			$error("busy high while ready is low");
			failures++;
		end

	// unsigned difference, so a decrease shows up as a large value
	pill_count_per_step: assert property (@(posedge clock_50) disable iff (!rst_n)
		busy |-> (11'(pill_count - count_at_take) <= 11'd1))
		else begin
			$error("pill_count decreased or rose by more than one in a step");
			failures++;
		end

	// the count only moves inside a step
	pill_count_in_step: assert property (@(posedge clock_50) disable iff (!rst_n)
		$past(rst_n) && (pill_count != $past(pill_count)) |-> busy)
		else begin
			$error("pill_count changed outside a step");
			failures++;
		end

	// renderer pipeline has flushed the fill by then
	rgb_known: assert property (@(posedge clock_50) disable iff (!rst_n)
		ready && $past(ready, 3) |-> !$isunknown(rgb))
		else begin
			$error("rgb unknown after the map is ready");
			failures++;
		end

	game_won_sticky: assert property (@(posedge clock_50) disable iff (!rst_n)
		game_won |=> game_won)
		else begin
			$error("game_won fell after being set");
			failures++;
		end

endmodule

bind pacman_game_top pacman_game_properties pacman_game_properties_inst (.*);

// ==== design/pacman_game_top.sv ====
`include "pacman_consts.svh"

module pacman_game_top (
	input logic clock_50,
	input logic rst_n,
	input logic key_up,
	input logic key_down,
	input logic key_left,
	input logic key_right,
	input logic step,
	input pacman_video_pkg::pixel_pos_t pixel,
	output pacman_video_pkg::rgb_t rgb,
	output pacman_types_pkg::tile_pos_t pacman_pos,
	output logic [10:0] pill_count,
	output logic game_won,
	output pacman_types_pkg::coll_e last_coll,
	output logic busy,
	output logic ready
);
	import pacman_types_pkg::*;

	// game side
	dir_e dir;
	coll_e coll;
	tile_e probe_tile;
	tile_pos_t target;
	tile_pos_t from_pos;
	tile_pos_t to_pos;
	logic probe_req;
	logic probe_valid;
	logic commit;
	logic eat;
	logic write_done;

	// ram ports
	logic [4:0] addr_a;
	logic [4:0] addr_b;
	logic [`ROW_BITS-1:0] q_a;
	logic [`ROW_BITS-1:0] q_b;
	logic [`ROW_BITS-1:0] data_b;
	logic wren_b;

	key_direction_latch key_direction_latch_inst (.clock_50(clock_50), .rst_n(rst_n),
		.key_up(key_up), .key_down(key_down), .key_left(key_left), .key_right(key_right),
		.dir(dir));

	pacman_move_ctrl pacman_move_ctrl_inst (.clock_50(clock_50), .rst_n(rst_n),
		.step(step), .ready(ready), .dir(dir), .coll(coll), .probe_valid(probe_valid),
		.write_done(write_done), .probe_req(probe_req), .target(target), .commit(commit),
		.eat(eat), .from_pos(from_pos), .to_pos(to_pos), .pacman_pos(pacman_pos),
		.busy(busy), .last_coll(last_coll));

	collision_detect collision_detect_inst (.clock_50(clock_50), .rst_n(rst_n),
		.probe_valid(probe_valid), .probe_tile(probe_tile), .eat(eat), .coll(coll),
		.pill_count(pill_count), .game_won(game_won));

	// sole user of port b
	map_ram_writer map_ram_writer_inst (.clock_50(clock_50), .rst_n(rst_n),
		.probe_req(probe_req), .target(target), .commit(commit), .from_pos(from_pos),
		.to_pos(to_pos), .rdata(q_b), .addr(addr_b), .wdata(data_b), .wren(wren_b),
		.ready(ready), .probe_valid(probe_valid), .probe_tile(probe_tile),
		.write_done(write_done));

	tile_map_ram tile_map_ram_inst (.clock_50(clock_50), .addr_a(addr_a), .q_a(q_a),
		.addr_b(addr_b), .data_b(data_b), .wren_b(wren_b), .q_b(q_b));

	tile_renderer tile_renderer_inst (.clock_50(clock_50), .rst_n(rst_n), .pixel(pixel),
		.ram_addr(addr_a), .ram_q(q_a), .rgb(rgb));

endmodule

// ==== design/tile_renderer.sv ====
`include "pacman_consts.svh"

module tile_renderer (
	input logic clock_50,
	input logic rst_n,
	input pacman_video_pkg::pixel_pos_t pixel,
	output logic [4:0] ram_addr,
	input logic [`ROW_BITS-1:0] ram_q,
	output pacman_video_pkg::rgb_t rgb
);
	import pacman_types_pkg::*;
	import pacman_video_pkg::*;

	logic on_map;
	logic on_map_q;
	logic [5:0] col_q;
	logic [3:0] loc_x_q;
	logic [3:0] loc_y_q;
	tile_e tile;
	rgb_t colour;

	// stage one
	// tile row goes straight to the ram
	assign ram_addr = pixel.y[8:4];
	assign on_map = (pixel.x < 10'(`MAP_COLS * `TILE_PIX)) &&
		(pixel.y < 9'(`MAP_ROWS * `TILE_PIX));

	always_ff @(posedge clock_50) begin
		col_q <= pixel.x[9:4];
		loc_x_q <= pixel.x[3:0];
		loc_y_q <= pixel.y[3:0];
	end

	// stage two
	// nibble select, off-map pixels read as empty
	always_comb begin
		tile = tile_empty;
		if (on_map_q) tile = tile_e'(ram_q[(`MAP_COLS - 1 - col_q) * `TILE_BITS +: `TILE_BITS]);
	end

	always_comb begin
		case (tile)
			tile_wall: colour = `COLOR_WALL;
			tile_pac: colour = `COLOR_PAC;
			tile_pill: begin
				// small dot in the middle of the tile
				if (loc_x_q >= 4'(`PILL_LO) && loc_x_q <= 4'(`PILL_HI) &&
					loc_y_q >= 4'(`PILL_LO) && loc_y_q <= 4'(`PILL_HI))
					colour = `COLOR_PILL;
				else
					colour = '0;
			end
			// empty and unknown codes are black
			default: colour = '0;
		endcase
	end

	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			on_map_q <= 1'b0;
			rgb <= '0;
		end else begin
			on_map_q <= on_map;
			rgb <= colour;
		end
	end

endmodule

// ==== design/tile_map_ram.sv ====
`include "pacman_consts.svh"

module tile_map_ram (
	input logic clock_50,
	input logic [4:0] addr_a,
	output logic [`ROW_BITS-1:0] q_a,
	input logic [4:0] addr_b,
	input logic [`ROW_BITS-1:0] data_b,
	input logic wren_b,
	output logic [`ROW_BITS-1:0] q_b
);

	// one word per tile row
	logic [`ROW_BITS-1:0] mem [0:`MAP_ROWS-1];

	// port a, read only for the renderer
	always_ff @(posedge clock_50) begin
		q_a <= mem[addr_a];
	end

	// port b, read old data on a write
	always_ff @(posedge clock_50) begin
		if (wren_b) mem[addr_b] <= data_b;
		q_b <= mem[addr_b];
	end

endmodule

// ==== design/map_ram_writer.sv ====
`include "pacman_consts.svh"

module map_ram_writer (
	input logic clock_50,
	input logic rst_n,
	input logic probe_req,
	input pacman_types_pkg::tile_pos_t target,
	input logic commit,
	input pacman_types_pkg::tile_pos_t from_pos,
	input pacman_types_pkg::tile_pos_t to_pos,
	input logic [`ROW_BITS-1:0] rdata,
	output logic [4:0] addr,
	output logic [`ROW_BITS-1:0] wdata,
	output logic wren,
	output logic ready,
	output logic probe_valid,
	output pacman_types_pkg::tile_e probe_tile,
	output logic write_done
);
	import pacman_types_pkg::*;

	typedef enum logic [2:0] {
		st_fill,
		st_idle,
		st_prb_rd,
		st_prb_dat,
		st_old_rd,
		st_old_wr,
		st_new_rd,
		st_new_wr
	} state_e;

	state_e state;
	logic [4:0] fill_row;
	logic same_row;
	logic [`ROW_BITS-1:0] old_edit;

	// column 0 sits in the top nibble
	function automatic tile_e get_tile(input logic [`ROW_BITS-1:0] row, input logic [5:0] col);
		return tile_e'(row[(`MAP_COLS - 1 - col) * `TILE_BITS +: `TILE_BITS]);
	endfunction

	function automatic logic [`ROW_BITS-1:0] set_tile(input logic [`ROW_BITS-1:0] row,
		input logic [5:0] col, input tile_e t);
		logic [`ROW_BITS-1:0] res;
		res = row;
		res[(`MAP_COLS - 1 - col) * `TILE_BITS +: `TILE_BITS] = t;
		return res;
	endfunction

	// starting maze row
	function automatic logic [`ROW_BITS-1:0] maze_row(input logic [4:0] r);
		logic [`ROW_BITS-1:0] row;
		tile_e t;
		row = '0;
		for (int c = 0; c < `MAP_COLS; c++) begin
			if (r == 5'd0 || r == 5'(`MAP_ROWS - 1) || c == 0 || c == `MAP_COLS - 1)
				t = tile_wall;
			// pillar grid inside the border
			else if (!r[0] && (c % 2 == 0))
				t = tile_wall;
			else if (r == 5'(`START_Y) && c == `START_X)
				t = tile_pac;
			else
				t = tile_pill;
			row = set_tile(row, 6'(c), t);
		end
		return row;
	endfunction

	assign same_row = (from_pos.y == to_pos.y);
	// old row loses pac-man, and gains it back elsewhere on a same-row move
	assign old_edit = same_row ?
		set_tile(set_tile(rdata, from_pos.x, tile_empty), to_pos.x, tile_pac) :
		set_tile(rdata, from_pos.x, tile_empty);

	assign ready = (state != st_fill);
	assign probe_valid = (state == st_prb_dat);
	assign probe_tile = get_tile(rdata, target.x);
	assign write_done = (state == st_old_wr && same_row) || (state == st_new_wr);

	// port b address and write data per state
	always_comb begin
		addr = target.y;
		wdata = rdata;
		wren = 1'b0;
		case (state)
			st_fill: begin
				addr = fill_row;
				wdata = maze_row(fill_row);
				wren = 1'b1;
			end
			st_old_rd: addr = from_pos.y;
			st_old_wr: begin
				addr = from_pos.y;
				wdata = old_edit;
				wren = 1'b1;
			end
			st_new_rd: addr = to_pos.y;
			st_new_wr: begin
				addr = to_pos.y;
				wdata = set_tile(rdata, to_pos.x, tile_pac);
				wren = 1'b1;
			end
			default: addr = target.y;
		endcase
	end

	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_fill;
			fill_row <= '0;
		end else begin
			case (state)
				st_fill: begin
					fill_row <= fill_row + 5'd1;
					if (fill_row == 5'(`MAP_ROWS - 1)) state <= st_idle;
				end
				st_idle: begin
					if (probe_req) state <= st_prb_rd;
					else if (commit) state <= st_old_rd;
				end
				st_prb_rd: state <= st_prb_dat;
				st_old_rd: state <= st_old_wr;
				// second rmw only when the rows differ
				st_old_wr: state <= same_row ? st_idle : st_new_rd;
				st_new_rd: state <= st_new_wr;
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// ==== design/collision_detect.sv ====
`include "pacman_consts.svh"

module collision_detect (
	input logic clock_50,
	input logic rst_n,
	input logic probe_valid,
	input pacman_types_pkg::tile_e probe_tile,
	input logic eat,
	output pacman_types_pkg::coll_e coll,
	output logic [10:0] pill_count,
	output logic game_won
);
	import pacman_types_pkg::*;

	// answer in the probe data cycle
	always_comb begin
		coll = coll_none;
		if (probe_valid) begin
			case (probe_tile)
				tile_wall: coll = coll_wall;
				tile_pill: coll = coll_pill;
				// empty, and pac-man itself which never gets probed
				default: coll = coll_none;
			endcase
		end
	end

	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			pill_count <= '0;
			game_won <= 1'b0;
		end else begin
			if (eat) pill_count <= pill_count + 11'd1;
			// sticky once every pill is gone
			game_won <= game_won || (pill_count == 11'(`PILL_TOTAL));
		end
	end

endmodule

// ==== design/pacman_move_ctrl.sv ====
`include "pacman_consts.svh"

module pacman_move_ctrl (
	input logic clock_50,
	input logic rst_n,
	input logic step,
	input logic ready,
	input pacman_types_pkg::dir_e dir,
	input pacman_types_pkg::coll_e coll,
	input logic probe_valid,
	input logic write_done,
	output logic probe_req,
	output pacman_types_pkg::tile_pos_t target,
	output logic commit,
	output logic eat,
	output pacman_types_pkg::tile_pos_t from_pos,
	output pacman_types_pkg::tile_pos_t to_pos,
	output pacman_types_pkg::tile_pos_t pacman_pos,
	output logic busy,
	output pacman_types_pkg::coll_e last_coll
);
	import pacman_types_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_probe,
		st_commit,
		st_finish
	} state_e;

	state_e state;
	tile_pos_t next_pos;
	logic take;

	// neighbour tile in the held direction
	// the border is all wall so no wrap is possible
	always_comb begin
		next_pos = pacman_pos;
		case (dir)
			dir_up: next_pos.y = pacman_pos.y - 5'd1;
			dir_down: next_pos.y = pacman_pos.y + 5'd1;
			dir_left: next_pos.x = pacman_pos.x - 6'd1;
			dir_right: next_pos.x = pacman_pos.x + 6'd1;
			default: next_pos = pacman_pos;
		endcase
	end

	// steps outside idle are dropped, no queue
	assign take = step && ready && (state == st_idle) && (dir != dir_none);

	assign busy = (state != st_idle);
	// one cycle commit pulse, eat rides along on a pill
	assign commit = (state == st_commit);
	assign eat = (state == st_commit) && (last_coll == coll_pill);
	assign from_pos = pacman_pos;
	assign to_pos = target;

	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			probe_req <= 1'b0;
			pacman_pos <= '{x: 6'(`START_X), y: 5'(`START_Y)};
			last_coll <= coll_none;
		end else begin
			probe_req <= take;
			case (state)
				st_idle: begin
					if (take) state <= st_probe;
				end
				st_probe: begin
					// wall ends the step right here
					if (probe_valid) begin
						last_coll <= coll;
						state <= (coll == coll_wall) ? st_idle : st_commit;
					end
				end
				st_commit: begin
					state <= st_finish;
				end
				st_finish: begin
					if (write_done) begin
						pacman_pos <= target;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// target only moves when a step is taken
	always_ff @(posedge clock_50) begin
		if (take) target <= next_pos;
	end

endmodule

// ==== design/key_direction_latch.sv ====
module key_direction_latch (
	input logic clock_50,
	input logic rst_n,
	input logic key_up,
	input logic key_down,
	input logic key_left,
	input logic key_right,
	output pacman_types_pkg::dir_e dir
);
	import pacman_types_pkg::*;

	// last pressed direction, held when all keys are released
	// priority up, down, left, right
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			// nothing pressed yet
			dir <= dir_none;
		end else if (key_up) begin
			dir <= dir_up;
		end else if (key_down) begin
			dir <= dir_down;
		end else if (key_left) begin
			dir <= dir_left;
		end else if (key_right) begin
			dir <= dir_right;
		end
	end

endmodule

// ==== design/pacman_video_pkg.sv ====
package pacman_video_pkg;

	// screen pixel, x 0 to 639 and y 0 to 479
	typedef struct packed {
		logic [9:0] x;
		logic [8:0] y;
	} pixel_pos_t;

	// 8 bits per channel
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

endpackage

// ==== design/pacman_types_pkg.sv ====
package pacman_types_pkg;

	// tile codes stored in the map ram
	typedef enum logic [3:0] {
		tile_empty = 4'd0,
		tile_wall = 4'd1,
		tile_pill = 4'd2,
		tile_pac = 4'd3
	} tile_e;

	// held direction from the keys
	typedef enum logic [2:0] {
		dir_none,
		dir_up,
		dir_down,
		dir_left,
		dir_right
	} dir_e;

	// what the target tile of a step held
	typedef enum logic [1:0] {
		coll_none,
		coll_wall,
		coll_pill
	} coll_e;

	// tile coordinate, x 0 to 39 and y 0 to 29
	typedef struct packed {
		logic [5:0] x;
		logic [4:0] y;
	} tile_pos_t;

endpackage

// ==== include/pacman_consts.svh ====
`ifndef PACMAN_CONSTS_SVH
`define PACMAN_CONSTS_SVH

// map geometry in tiles
`define MAP_COLS 40
`define MAP_ROWS 30

// one tile code per nibble
`define TILE_BITS 4

// bits in one map row word, column 0 in the top nibble
`define ROW_BITS (`MAP_COLS * `TILE_BITS)

// tile edge in pixels
`define TILE_PIX 16

// pac-man start tile
`define START_X 1
`define START_Y 1

// pills in the starting maze
`define PILL_TOTAL 797

// local pixel window of the pill dot
`define PILL_LO 6
`define PILL_HI 9

// colours as r, g, b
`define COLOR_WALL {8'd0, 8'd0, 8'd255}
`define COLOR_PILL {8'd255, 8'd255, 8'd255}
`define COLOR_PAC {8'd255, 8'd255, 8'd0}

`endif
